//--- logic/trace_pkg.sv
// Shared definitions for the trace monitoring subsystem.
// Holds the core count, the simulation no-op encodings and the trace and
// event structs; modules refer to them as trace_pkg::name.

package trace_pkg;

   // Number of traced cores and the width of a core index
   localparam int num_cores = 4;
   localparam int core_id_w = 2;

   // l.nop lives in the top byte of the instruction word
   localparam logic [7:0] nop_opcode = 8'h15;

   // Immediates of the simulation no-ops
   localparam logic [15:0] nop_k_exit   = 16'h0001;
   localparam logic [15:0] nop_k_report = 16'h0002;
   localparam logic [15:0] nop_k_putc   = 16'h0004;

   // General register carrying the no-op argument
   localparam logic [4:0] r3_index = 5'd3;

   // One core's execute trace for one cycle
   typedef struct packed {
      logic        valid;
      logic [31:0] pc;
      logic [31:0] insn;
      logic        wben;
      logic [4:0]  wbreg;
      logic [31:0] wbdata;
   } trace_t;

   // Decoded no-op kind, ev_none when nothing happened
   typedef enum logic [1:0] {
      ev_none,
      ev_exit,
      ev_report,
      ev_putc
   } nop_kind_e;

   // Event from a single core monitor
   typedef struct packed {
      nop_kind_e   kind;
      logic [31:0] value;
   } core_event_t;

   // Merged event, tagged with the source core
   typedef struct packed {
      logic [core_id_w-1:0] core;
      nop_kind_e            kind;
      logic [31:0]          value;
   } sys_event_t;

endpackage

//--- logic/trace_monitor.sv
// Per-core trace monitor.
// Shadows r3 from the writeback trace and decodes the simulation no-ops
// into a registered one-cycle core event. Stops after the core's own exit.

`timescale 1ns/1ps

module trace_monitor (
   input  logic                   clk,
   input  logic                   rst_n,
   input  trace_pkg::trace_t      trace,
   output trace_pkg::core_event_t event_out
);

   // Shadow of r3 as of the previous trace entries
   logic [31:0] r3_q;

   // Set once this core has reported its exit
   logic halted;

   // Decode results for the current entry
   trace_pkg::nop_kind_e nop_kind;
   logic [31:0]          nop_value;

   // Registered event fields
   trace_pkg::nop_kind_e kind_q;
   logic [31:0]          value_q;

   // Classify the no-op immediate
   always_comb begin
      nop_kind = trace_pkg::ev_none;
      if (trace.valid && trace.insn[31:24] == trace_pkg::nop_opcode) begin
         case (trace.insn[15:0])
            trace_pkg::nop_k_exit:   nop_kind = trace_pkg::ev_exit;
            trace_pkg::nop_k_report: nop_kind = trace_pkg::ev_report;
            trace_pkg::nop_k_putc:   nop_kind = trace_pkg::ev_putc;
            default:                 nop_kind = trace_pkg::ev_none;
         endcase
      end
   end

   // putc carries only the character byte
   assign nop_value = (nop_kind == trace_pkg::ev_putc) ? {24'h0, r3_q[7:0]} : r3_q;

   // Shadow r3, halt flag and event kind
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         r3_q   <= '0;
         halted <= 1'b0;
         kind_q <= trace_pkg::ev_none;
      end else begin
         // Only qualified writebacks to r3
         if (trace.valid && trace.wben && trace.wbreg == trace_pkg::r3_index) begin
            r3_q <= trace.wbdata;
         end
         kind_q <= halted ? trace_pkg::ev_none : nop_kind;
         if (nop_kind == trace_pkg::ev_exit) begin
            halted <= 1'b1;
         end
      end
   end

   // Event payload taken from the shadow
   always_ff @(posedge clk) begin
      value_q <= nop_value;
   end

   assign event_out = '{kind: kind_q, value: value_q};

endmodule

//--- logic/event_arbiter.sv
// Merges the per-core event strobes into one event stream.
// Each core owns a one-entry pending slot; one slot is emitted per cycle
// in round-robin order. An event hitting a full slot is dropped and the
// core's sticky overflow bit sets.

`timescale 1ns/1ps

module event_arbiter (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  trace_pkg::core_event_t                 core_events [trace_pkg::num_cores],
   output logic                                   evt_valid,
   output trace_pkg::sys_event_t                  evt,
   output logic [trace_pkg::num_cores-1:0]        overflow
);

   // Pending slots
   logic [trace_pkg::num_cores-1:0] slot_full;
   trace_pkg::core_event_t          slot_evt [trace_pkg::num_cores];

   // Last core served
   logic [trace_pkg::core_id_w-1:0] rr_ptr;

   // Grant for this cycle
   logic                            grant_valid;
   logic [trace_pkg::core_id_w-1:0] grant_idx;
   logic [trace_pkg::num_cores-1:0] grant_oh;
   int                              cand;

   // First full slot after the pointer, wrapping around
   always_comb begin
      grant_valid = 1'b0;
      grant_idx   = '0;
      grant_oh    = '0;
      cand        = 0;
      for (int i = 1; i <= trace_pkg::num_cores; i++) begin
         cand = (int'(rr_ptr) + i) % trace_pkg::num_cores;
         if (!grant_valid && slot_full[cand]) begin
            grant_valid    = 1'b1;
            grant_idx      = cand[trace_pkg::core_id_w-1:0];
            grant_oh[cand] = 1'b1;
         end
      end
   end

   // Slot occupancy, pointer and overflow
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         slot_full <= '0;
         overflow  <= '0;
         rr_ptr    <= '0;
         evt_valid <= 1'b0;
      end else begin
         for (int c = 0; c < trace_pkg::num_cores; c++) begin
            if (core_events[c].kind != trace_pkg::ev_none) begin
               // Emission frees the slot in time for the newcomer
               if (!slot_full[c] || grant_oh[c]) begin
                  slot_full[c] <= 1'b1;
               end else begin
                  overflow[c] <= 1'b1;
               end
            end else if (grant_oh[c]) begin
               slot_full[c] <= 1'b0;
            end
         end
         if (grant_valid) begin
            rr_ptr <= grant_idx;
         end
         evt_valid <= grant_valid;
      end
   end

   // Slot contents and the output event
   always_ff @(posedge clk) begin
      for (int c = 0; c < trace_pkg::num_cores; c++) begin
         if (core_events[c].kind != trace_pkg::ev_none && (!slot_full[c] || grant_oh[c])) begin
            slot_evt[c] <= core_events[c];
         end
      end
      if (grant_valid) begin
         evt.core  <= grant_idx;
         evt.kind  <= slot_evt[grant_idx].kind;
         evt.value <= slot_evt[grant_idx].value;
      end
   end

endmodule

//--- logic/termination_tracker.sv
// Records each core's exit code from its exit event.
// exited is a sticky per-core level; term_all follows one cycle after the
// last core has exited and holds until reset.

`timescale 1ns/1ps

module termination_tracker (
   input  logic                            clk,
   input  logic                            rst_n,
   input  trace_pkg::core_event_t          core_events [trace_pkg::num_cores],
   output logic [trace_pkg::num_cores-1:0] exited,
   output logic [31:0]                     exit_code [trace_pkg::num_cores],
   output logic                            term_all
);

   // Exit latches
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         exited <= '0;
         for (int c = 0; c < trace_pkg::num_cores; c++) begin
            exit_code[c] <= '0;
         end
      end else begin
         for (int c = 0; c < trace_pkg::num_cores; c++) begin
            // First exit wins, monitor halts afterwards anyway
            if (core_events[c].kind == trace_pkg::ev_exit && !exited[c]) begin
               exited[c]    <= 1'b1;
               exit_code[c] <= core_events[c].value;
            end
         end
      end
   end

   // System-wide termination
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         term_all <= 1'b0;
      end else begin
         // exited bits never fall, so this level stays up
         term_all <= &exited;
      end
   end

endmodule

//--- logic/trace_mon_top.sv
// Top level of the trace monitoring subsystem.
// One monitor per core feeds both the event arbiter and the
// termination tracker. The testbench drives the per-core traces.

`timescale 1ns/1ps

module trace_mon_top (
   input  logic                            clk,
   input  logic                            rst_n,
   input  trace_pkg::trace_t               trace [trace_pkg::num_cores],
   output logic                            evt_valid,
   output trace_pkg::sys_event_t           evt,
   output logic [trace_pkg::num_cores-1:0] overflow,
   output logic [trace_pkg::num_cores-1:0] exited,
   output logic [31:0]                     exit_code [trace_pkg::num_cores],
   output logic                            term_all
);

   // Per-core event strobes
   trace_pkg::core_event_t core_events [trace_pkg::num_cores];

   // One monitor per core
   for (genvar c = 0; c < trace_pkg::num_cores; c++) begin : gen_core
      trace_monitor u_trace_monitor (
         .clk       (clk),
         .rst_n     (rst_n),
         .trace     (trace[c]),
         .event_out (core_events[c])
      );
   end

   // Round-robin merge into the event stream
   event_arbiter u_event_arbiter (
      .clk         (clk),
      .rst_n       (rst_n),
      .core_events (core_events),
      .evt_valid   (evt_valid),
      .evt         (evt),
      .overflow    (overflow)
   );

   // Exit codes and termination
   termination_tracker u_termination_tracker (
      .clk         (clk),
      .rst_n       (rst_n),
      .core_events (core_events),
      .exited      (exited),
      .exit_code   (exit_code),
      .term_all    (term_all)
   );

endmodule

//--- dv/trace_mon_sva.sv
// Concurrent checks on the outputs of the trace monitoring top level.
// Bound into trace_mon_top; failures raise $error and bump fail_count,
// which the testbench reads for its closing verdict.

`timescale 1ns/1ps

module trace_mon_sva (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            evt_valid,
   input  trace_pkg::sys_event_t           evt,
   input  logic [trace_pkg::num_cores-1:0] overflow,
   input  logic [trace_pkg::num_cores-1:0] exited,
   input  logic [31:0]                     exit_code [trace_pkg::num_cores],
   input  logic                            term_all
);

   int fail_count = 0;

   // Synchronous reset clears every output on the following edge
   reset_clears: assert property (@(posedge clk)
      !rst_n |=> (!evt_valid && overflow == '0 && exited == '0 && !term_all))
      else begin
         $error("outputs not cleared by reset");
         fail_count++;
      end

   // Exit codes cleared as well
   for (genvar c = 0; c < trace_pkg::num_cores; c++) begin : gen_code
      code_reset: assert property (@(posedge clk) !rst_n |=> exit_code[c] == '0)
         else begin
            $error("exit code of core %0d not cleared by reset", c);
            fail_count++;
         end
   end

   // Termination only once every core is out
   term_needs_all: assert property (@(posedge clk) disable iff (!rst_n)
      term_all |-> &exited)
      else begin
         $error("term_all high while a core is still running");
         fail_count++;
      end

   // A strobe always carries a real kind
   valid_has_kind: assert property (@(posedge clk) disable iff (!rst_n)
      evt_valid |-> evt.kind != trace_pkg::ev_none)
      else begin
         $error("evt_valid with kind ev_none");
         fail_count++;
      end

   // Sticky exit bits
   exited_sticky: assert property (@(posedge clk) disable iff (!rst_n)
      ($past(exited) & ~exited) == '0)
      else begin
         $error("an exited bit fell");
         fail_count++;
      end

endmodule

bind trace_mon_top trace_mon_sva u_sva (.*);

//--- dv/tb_trace_mon.sv
// Testbench for trace_mon_top.
// Plays per-core execute traces, predicts events from an r3 model per core
// and checks the merged stream, overflow, exit codes and termination.

`timescale 1ns/1ps

module tb_trace_mon;

   logic                            clk = 1'b0;
   logic                            rst_n;
   trace_pkg::trace_t               trace [trace_pkg::num_cores];
   logic                            evt_valid;
   trace_pkg::sys_event_t           evt;
   logic [trace_pkg::num_cores-1:0] overflow;
   logic [trace_pkg::num_cores-1:0] exited;
   logic [31:0]                     exit_code [trace_pkg::num_cores];
   logic                            term_all;

   // Entry each core drives on the next step
   trace_pkg::trace_t      next_trace [trace_pkg::num_cores];
   // Reference r3 and halt state
   logic [31:0]            r3_ref [trace_pkg::num_cores];
   logic                   halted_ref [trace_pkg::num_cores];
   // Loose cores are only counted and not matched
   logic                   loose [trace_pkg::num_cores];
   int                     issued [trace_pkg::num_cores];
   int                     got [trace_pkg::num_cores];
   trace_pkg::core_event_t exp_q [trace_pkg::num_cores][$];
   trace_pkg::core_event_t exp_evt;
   int                     errors;
   int                     evt_matches;
   int                     code_matches;

   always #2 clk = ~clk;

   trace_mon_top u_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .trace     (trace),
      .evt_valid (evt_valid),
      .evt       (evt),
      .overflow  (overflow),
      .exited    (exited),
      .exit_code (exit_code),
      .term_all  (term_all)
   );

   function automatic trace_pkg::trace_t nop_entry(input logic [15:0] imm);
      trace_pkg::trace_t t;
      t       = '0;
      t.valid = 1'b1;
      t.pc    = $urandom;
      t.insn  = {trace_pkg::nop_opcode, 8'h00, imm};
      return t;
   endfunction

   // Plain instruction with a writeback and an opcode byte other than the no-op
   function automatic trace_pkg::trace_t wb_entry(input logic valid, input logic wben,
                                                  input logic [4:0] wbreg,
                                                  input logic [31:0] data);
      trace_pkg::trace_t t;
      t        = '0;
      t.valid  = valid;
      t.pc     = $urandom;
      t.insn   = {8'he0, 24'($urandom)};
      t.wben   = wben;
      t.wbreg  = wbreg;
      t.wbdata = data;
      return t;
   endfunction

   // Drive one entry per core and advance the reference model
   task automatic step();
      logic [15:0]            imm;
      trace_pkg::core_event_t e;
      @(posedge clk);
      for (int c = 0; c < trace_pkg::num_cores; c++) begin
         trace[c] <= next_trace[c];
         imm = next_trace[c].insn[15:0];
         if (next_trace[c].valid && next_trace[c].insn[31:24] == trace_pkg::nop_opcode &&
             !halted_ref[c] && (imm == trace_pkg::nop_k_exit ||
             imm == trace_pkg::nop_k_report || imm == trace_pkg::nop_k_putc)) begin
            if (imm == trace_pkg::nop_k_exit) e.kind = trace_pkg::ev_exit;
            else if (imm == trace_pkg::nop_k_report) e.kind = trace_pkg::ev_report;
            else e.kind = trace_pkg::ev_putc;
            // Value is r3 from before this entry
            e.value = (e.kind == trace_pkg::ev_putc) ? {24'h0, r3_ref[c][7:0]} : r3_ref[c];
            if (loose[c]) issued[c]++;
            else exp_q[c].push_back(e);
            if (e.kind == trace_pkg::ev_exit) halted_ref[c] = 1'b1;
         end
         if (next_trace[c].valid && next_trace[c].wben &&
             next_trace[c].wbreg == trace_pkg::r3_index) begin
            r3_ref[c] = next_trace[c].wbdata;
         end
         next_trace[c] = '0;
      end
   endtask

   // Idle until every expected event has been seen
   task automatic wait_drained(input int limit, input string what);
      int   n;
      logic busy;
      n    = 0;
      busy = 1'b1;
      while (busy && n < limit) begin
         step();
         @(negedge clk);
         busy = 1'b0;
         for (int c = 0; c < trace_pkg::num_cores; c++) begin
            if (exp_q[c].size() != 0) busy = 1'b1;
         end
         n++;
      end
      if (busy) begin
         $display("Timeout: %s, events still missing after %0d cycles", what, limit);
         errors++;
      end
   endtask

   task automatic report_test(input int num, input string name, input int errs_before);
      $display("Test %0d %s: %s", num, name, (errors == errs_before) ? "ok" : "FAILED");
   endtask

   // Scoreboard on the merged stream
   always @(posedge clk) begin
      if (rst_n && evt_valid) begin
         got[evt.core]++;
         if (!loose[evt.core]) begin
            assert (exp_q[evt.core].size() != 0) else begin
               $display("Error at %0t: unexpected event kind %0d from core %0d",
                        $time, evt.kind, evt.core);
               errors++;
            end
            if (exp_q[evt.core].size() != 0) begin
               exp_evt = exp_q[evt.core].pop_front();
               assert (evt.kind == exp_evt.kind && evt.value == exp_evt.value) evt_matches++;
               else begin
                  $display("Error at %0t: core %0d got kind %0d value %h, expected %0d %h",
                           $time, evt.core, evt.kind, evt.value, exp_evt.kind, exp_evt.value);
                  errors++;
               end
            end
         end
      end
   end

   initial begin
      int          errs_before;
      int          pick;
      logic [31:0] val;
      void'($urandom(32'he703));
      rst_n = 1'b0;
      for (int c = 0; c < trace_pkg::num_cores; c++) begin
         trace[c]      = '0;
         next_trace[c] = '0;
         r3_ref[c]     = '0;
         halted_ref[c] = 1'b0;
         loose[c]      = 1'b0;
         issued[c]     = 0;
         got[c]        = 0;
      end
      errors       = 0;
      evt_matches  = 0;
      code_matches = 0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;

      // Quiet outputs with no trace activity
      errs_before = errors;
      for (int k = 0; k < trace_pkg::num_cores + 4; k++) begin
         step();
         @(negedge clk);
         assert (!evt_valid && overflow == '0 && exited == '0 && !term_all) else begin
            $display("Error at %0t: outputs not idle after reset", $time);
            errors++;
         end
      end
      report_test(1, "reset", errs_before);

      // Random writebacks with a putc or report from one core per cycle
      errs_before = errors;
      for (int r = 0; r < 12; r++) begin
         for (int k = 0; k < trace_pkg::num_cores; k++) begin
            for (int c = 0; c < trace_pkg::num_cores; c++) begin
               pick = $urandom_range(3, 0);
               val  = $urandom;
               case (pick)
                  0: next_trace[c] = wb_entry(1'b1, 1'b1, trace_pkg::r3_index, val);
                  1: next_trace[c] = wb_entry(1'b1, 1'b1, 5'($urandom_range(31, 4)), val);
                  2: next_trace[c] = wb_entry(1'b1, 1'b0, trace_pkg::r3_index, val);
                  default: next_trace[c] = wb_entry(1'b0, 1'b1, trace_pkg::r3_index, val);
               endcase
            end
            pick = $urandom_range(2, 0);
            if (pick == 1) next_trace[k] = nop_entry(trace_pkg::nop_k_putc);
            else if (pick == 2) next_trace[k] = nop_entry(trace_pkg::nop_k_report);
            step();
         end
      end
      wait_drained(50, "putc and report");
      report_test(2, "putc and report", errs_before);

      // All cores report in the same cycle
      errs_before = errors;
      for (int c = 0; c < trace_pkg::num_cores; c++) begin
         next_trace[c] = wb_entry(1'b1, 1'b1, trace_pkg::r3_index, $urandom);
      end
      step();
      for (int c = 0; c < trace_pkg::num_cores; c++) begin
         next_trace[c] = nop_entry(trace_pkg::nop_k_report);
      end
      step();
      wait_drained(trace_pkg::num_cores + 3, "simultaneous reports");
      assert (overflow == '0) else begin
         $display("Error at %0t: overflow %b after simultaneous reports", $time, overflow);
         errors++;
      end
      report_test(3, "simultaneous events", errs_before);

      // Core 0 floods its slot while the others stay within their share
      errs_before = errors;
      loose[0]    = 1'b1;
      got[0]      = 0;
      issued[0]   = 0;
      for (int k = 0; k < 12; k++) begin
         next_trace[0] = nop_entry(trace_pkg::nop_k_report);
         for (int c = 1; c < trace_pkg::num_cores; c++) begin
            if (k % trace_pkg::num_cores == c) next_trace[c] = nop_entry(trace_pkg::nop_k_putc);
         end
         step();
      end
      wait_drained(50, "overflow traffic");
      // Longest event latency for the last flood entry
      for (int k = 0; k < trace_pkg::num_cores + 2; k++) begin
         step();
      end
      @(negedge clk);
      assert (overflow == 4'b0001 && got[0] >= 1 && got[0] < issued[0]) else begin
         $display("Error at %0t: overflow %b, core 0 issued %0d and emitted %0d",
                  $time, overflow, issued[0], got[0]);
         errors++;
      end
      loose[0] = 1'b0;
      report_test(4, "overflow", errs_before);

      // Cores exit one by one
      errs_before = errors;
      for (int c = 0; c < trace_pkg::num_cores; c++) begin
         next_trace[c] = wb_entry(1'b1, 1'b1, trace_pkg::r3_index, $urandom);
         step();
         val           = r3_ref[c];
         next_trace[c] = nop_entry(trace_pkg::nop_k_exit);
         step();
         for (int k = 1; k <= 3; k++) begin
            step();
            @(negedge clk);
            // exited two cycles after the exit entry
            assert (exited[c] == (k >= 2)) else begin
               $display("Error at %0t: core %0d exited %b at cycle %0d after its exit",
                        $time, c, exited[c], k);
               errors++;
            end
            // term_all three cycles after the last exit entry
            assert (term_all == (k == 3 && c == trace_pkg::num_cores - 1)) else begin
               $display("Error at %0t: term_all %b after exit of core %0d", $time, term_all, c);
               errors++;
            end
         end
         wait_drained(50, "exit event");
         assert (exit_code[c] == val) code_matches++;
         else begin
            $display("Error at %0t: core %0d exit code %h, expected %h",
                     $time, c, exit_code[c], val);
            errors++;
         end
      end
      // No-ops after exit must stay silent
      for (int k = 0; k < 3; k++) begin
         for (int c = 0; c < trace_pkg::num_cores; c++) begin
            next_trace[c] = nop_entry((k == 0) ? trace_pkg::nop_k_report :
                                      (k == 1) ? trace_pkg::nop_k_putc : trace_pkg::nop_k_exit);
         end
         step();
      end
      for (int k = 0; k < trace_pkg::num_cores + 3; k++) begin
         step();
      end
      @(negedge clk);
      assert (term_all) else begin
         $display("Error at %0t: term_all dropped after all exits", $time);
         errors++;
      end
      report_test(5, "termination", errs_before);

      $display("Summary: %0d events ok, %0d exit codes ok, %0d errors, %0d assertion failures",
               evt_matches, code_matches, errors, u_dut.u_sva.fail_count);
      if (errors == 0 && u_dut.u_sva.fail_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

//--- list.f
logic/trace_pkg.sv
logic/trace_monitor.sv
logic/event_arbiter.sv
logic/termination_tracker.sv
logic/trace_mon_top.sv
dv/trace_mon_sva.sv
dv/tb_trace_mon.sv

//--- Bender.yml
package:
  name: trace_mon

sources:
  - logic/trace_pkg.sv
  - logic/trace_monitor.sv
  - logic/event_arbiter.sv
  - logic/termination_tracker.sv
  - logic/trace_mon_top.sv
  - target: simulation
    files:
      - dv/trace_mon_sva.sv
      - dv/tb_trace_mon.sv
